/* csi_rx.f */
+incdir+source
source/csi_rx_pkg.sv
source/payload_fifo.sv
source/csi_packet_handler.sv
source/csi_rx_12bit_unpack.sv
source/csi_rx_payload.sv
tb/csi_rx_payload_tb.sv

/* Makefile */
SIM = obj_dir/Vcsi_rx_payload_tb

.PHONY: all run lint clean

all: run

$(SIM): csi_rx.f source/*.sv source/*.svh tb/*.sv
	verilator --binary --timing --assert -f csi_rx.f --top-module csi_rx_payload_tb \
		-o Vcsi_rx_payload_tb

run: $(SIM)
	$(SIM) > sim.log 2>&1; cat sim.log
	@grep -q "Simulation passed" sim.log
	@! grep -q "Simulation failed" sim.log

lint:
	verilator --lint-only --timing --assert -f csi_rx.f --top-module csi_rx_payload_tb

clean:
	rm -rf obj_dir sim.log

/* tb/csi_rx_payload_tb.sv */
`include "csi_rx_params.svh"

module csi_rx_payload_tb;
   import csi_rx_pkg::*;

   logic           clock;
   logic           reset;
   logic [31:0]    lane_data;
   logic           lane_valid;
   logic           lane_ready;
   lane_raw_data_t pixel_data;
   logic           pixel_last;
   logic           pixel_valid;
   logic           pixel_ready;
   logic           packet_error;

   lane_raw_data_t exp_q [$];         // groups still to come out
   logic           last_q [$];
   lane_raw_data_t exp_data = '0;     // queue head, as a register
   logic           exp_last = 1'b0;
   logic           exp_valid = 1'b0;
   int             seed;
   int             stall_percent;     // chance of pixel_ready low
   int             errors_expected = 0;
   int             errors_seen = 0;
   int             check_errors = 0;
   int             wait_errors = 0;
   int             tests_run = 0;
   int             tests_failed = 0;
   int             failures_before = 0;

   csi_rx_payload csi_rx_payload_i (
      .clock        (clock),
      .reset        (reset),
      .lane_data    (lane_data),
      .lane_valid   (lane_valid),
      .lane_ready   (lane_ready),
      .pixel_data   (pixel_data),
      .pixel_last   (pixel_last),
      .pixel_valid  (pixel_valid),
      .pixel_ready  (pixel_ready),
      .packet_error (packet_error)
   );

   initial begin
      clock = 1'b0;
   end

   always #20 clock = ~clock;

   // scoreboard, pops on each output transfer
   always @(posedge clock) begin
      if (pixel_valid && pixel_ready && (exp_q.size() > 0)) begin
         void'(exp_q.pop_front());
         void'(last_q.pop_front());
      end
      if (packet_error) begin
         errors_seen = errors_seen + 1;
      end
      exp_valid <= exp_q.size() > 0;
      if (exp_q.size() > 0) begin
         exp_data <= exp_q[0];
         exp_last <= last_q[0];
      end
   end

   reset_state_a : assert property (@(posedge clock)
      $fell(reset) |-> lane_ready && !pixel_valid && !packet_error)
      else begin
         $display("%0t: outputs not idle after reset", $time);
         check_errors = check_errors + 1;
      end

   no_extra_a : assert property (@(posedge clock) disable iff (reset)
      pixel_valid && pixel_ready |-> exp_valid)
      else begin
         $display("%0t: pixel group delivered with none expected", $time);
         check_errors = check_errors + 1;
      end

   data_a : assert property (@(posedge clock) disable iff (reset)
      pixel_valid && pixel_ready && exp_valid |-> pixel_data == exp_data)
      else begin
         $display("ERR %0t pixel_data expected %h actual %h",
                  $time, $sampled(exp_data), $sampled(pixel_data));
         check_errors = check_errors + 1;
      end

   last_a : assert property (@(posedge clock) disable iff (reset)
      pixel_valid && pixel_ready && exp_valid |-> pixel_last == exp_last)
      else begin
         $display("ERR %0t pixel_last expected %b actual %b",
                  $time, $sampled(exp_last), $sampled(pixel_last));
         check_errors = check_errors + 1;
      end

   hold_a : assert property (@(posedge clock) disable iff (reset)
      pixel_valid && !pixel_ready |=>
         pixel_valid && $stable(pixel_data) && $stable(pixel_last))
      else begin
         $display("%0t: pixel output dropped or changed while pixel_ready was low", $time);
         check_errors = check_errors + 1;
      end

   error_expected_a : assert property (@(posedge clock) disable iff (reset)
      packet_error |-> errors_seen < errors_expected)
      else begin
         $display("%0t: packet_error pulsed for a packet that should be accepted", $time);
         check_errors = check_errors + 1;
      end

   error_pulse_a : assert property (@(posedge clock) disable iff (reset)
      packet_error |=> !packet_error)
      else begin
         $display("%0t: packet_error lasted longer than one cycle", $time);
         check_errors = check_errors + 1;
      end

   task automatic next_cycle();
      @(posedge clock);
      if (stall_percent > 0) begin
         pixel_ready <= ($unsigned($random(seed)) % 100) >= stall_percent;
      end else begin
         pixel_ready <= 1'b1;
      end
   endtask

   task automatic idle(input int cycles);
      lane_valid <= 1'b0;
      repeat (cycles) next_cycle();
   endtask

   task automatic send_word(input logic [31:0] word);
      int   waited;
      logic accepted;
      waited   = 0;
      accepted = 1'b0;
      lane_data  <= word;
      lane_valid <= 1'b1;
      while (!accepted && (waited < 200)) begin
         @(negedge clock);
         accepted = lane_ready;   // transfer at the coming edge
         next_cycle();
         waited++;
      end
      if (!accepted) begin
         $display("%0t: timeout, lane_ready stayed low for 200 cycles", $time);
         wait_errors = wait_errors + 1;
      end
   endtask

   task automatic send_packet(input logic [5:0] data_type, input logic [15:0] word_count,
                              input logic corrupt_check);
      logic [7:0]     id_byte;
      logic [7:0]     check_byte;
      logic [7:0]     payload [$];
      lane_raw_data_t pixels;
      logic           will_accept;
      int             n_words;
      int             n_groups;
      id_byte    = {2'b00, data_type};
      check_byte = id_byte ^ word_count[7:0] ^ word_count[15:8];
      if (corrupt_check) begin
         check_byte = check_byte ^ 8'h10;
      end
      will_accept = (data_type == `CSI_DT_RAW12) && !corrupt_check &&
                    (word_count != 16'd0) && ((word_count % 16'd12) == 16'd0) &&
                    (word_count <= `CSI_MAX_WORD_COUNT);
      n_words  = int'(word_count >> 2);
      n_groups = (n_words * 4) / 6;
      for (int i = 0; i < n_words * 4; i++) begin
         payload.push_back(8'($random(seed)));
      end
      if (will_accept) begin
         for (int g = 0; g < n_groups; g++) begin
            pixels[0] = {payload[6*g],   payload[6*g+2][3:0]};
            pixels[1] = {payload[6*g+1], payload[6*g+2][7:4]};
            pixels[2] = {payload[6*g+3], payload[6*g+5][3:0]};
            pixels[3] = {payload[6*g+4], payload[6*g+5][7:4]};
            exp_q.push_back(pixels);
            last_q.push_back(g == n_groups - 1);
         end
      end else begin
         errors_expected = errors_expected + 1;
      end
      send_word({check_byte, word_count[15:8], word_count[7:0], id_byte});
      for (int w = 0; w < n_words; w++) begin
         send_word({payload[4*w+3], payload[4*w+2], payload[4*w+1], payload[4*w]});
      end
   endtask

   // until every expected group and error pulse has been seen
   task automatic wait_drain();
      int waited;
      waited = 0;
      lane_valid <= 1'b0;
      @(negedge clock);
      while (((exp_q.size() != 0) || (errors_seen != errors_expected)) && (waited < 3000)) begin
         next_cycle();
         @(negedge clock);
         waited++;
      end
      if ((exp_q.size() != 0) || (errors_seen != errors_expected)) begin
         $display("%0t: timeout, %0d pixel groups and %0d packet_error pulses still missing",
                  $time, exp_q.size(), errors_expected - errors_seen);
         wait_errors = wait_errors + 1;
      end
      next_cycle();
   endtask

   task automatic finish_test(input string name);
      int failures;
      failures  = check_errors + wait_errors - failures_before;
      tests_run = tests_run + 1;
      if (failures == 0) begin
         $display("test %0d %s: ok", tests_run, name);
      end else begin
         tests_failed = tests_failed + 1;
         $display("test %0d %s: FAILED with %0d errors", tests_run, name, failures);
      end
      failures_before = check_errors + wait_errors;
   endtask

   initial begin
      seed          = 32'h6e85_64ad;
      stall_percent = 0;
      reset         = 1'b1;
      lane_data     = '0;
      lane_valid    = 1'b0;
      pixel_ready   = 1'b1;
      repeat (5) @(posedge clock);
      reset <= 1'b0;
      idle(3);

      send_packet(`CSI_DT_RAW12, 16'd24, 1'b0);
      wait_drain();
      finish_test("raw12 packet of 24 bytes");

      stall_percent = 40;   // random back-pressure on the output
      send_packet(`CSI_DT_RAW12, 16'd96, 1'b0);
      wait_drain();
      stall_percent = 0;
      finish_test("96 bytes under output stalls");

      send_packet(6'h2B, 16'd24, 1'b0);
      idle(3);
      send_packet(`CSI_DT_RAW12, 16'd24, 1'b0);
      wait_drain();
      finish_test("wrong data type rejected");

      send_packet(`CSI_DT_RAW12, 16'd36, 1'b1);
      idle(3);
      send_packet(`CSI_DT_RAW12, 16'd36, 1'b0);
      wait_drain();
      finish_test("wrong check byte rejected");

      send_packet(`CSI_DT_RAW12, 16'd0, 1'b0);
      idle(3);
      send_packet(`CSI_DT_RAW12, 16'd20, 1'b0);
      idle(3);
      send_packet(`CSI_DT_RAW12, 16'd12, 1'b0);
      wait_drain();
      finish_test("word counts 0 and 20 rejected");

      send_packet(`CSI_DT_RAW12, 16'd12, 1'b0);   // back to back
      send_packet(`CSI_DT_RAW12, 16'd36, 1'b0);
      send_packet(`CSI_DT_RAW12, 16'd24, 1'b0);
      wait_drain();
      finish_test("three packets back to back");

      idle(4);
      $display("%0d tests, %0d failed, %0d check errors, %0d timeouts",
               tests_run, tests_failed, check_errors, wait_errors);
      if ((tests_failed == 0) && (check_errors == 0) && (wait_errors == 0)) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

/* source/csi_rx_payload.sv */
`include "csi_rx_params.svh"

module csi_rx_payload (
   input  logic                       clock,
   input  logic                       reset,
   input  logic [31:0]                lane_data,
   input  logic                       lane_valid,
   output logic                       lane_ready,
   output csi_rx_pkg::lane_raw_data_t pixel_data,
   output logic                       pixel_last,
   output logic                       pixel_valid,
   input  logic                       pixel_ready,
   output logic                       packet_error
);

   logic [31:0] payload_word;   // handler to FIFO
   logic        payload_last;
   logic        payload_valid;
   logic        payload_ready;
   logic [31:0] fifo_word;      // FIFO to unpacker
   logic        fifo_last;
   logic        fifo_valid;
   logic        fifo_ready;

   csi_packet_handler csi_packet_handler_i (
      .clock         (clock),
      .reset         (reset),
      .lane_data     (lane_data),
      .lane_valid    (lane_valid),
      .lane_ready    (lane_ready),
      .payload_word  (payload_word),
      .payload_last  (payload_last),
      .payload_valid (payload_valid),
      .payload_ready (payload_ready),
      .packet_error  (packet_error)
   );

   payload_fifo #(
      .depth (`PAYLOAD_FIFO_DEPTH)
   ) payload_fifo_i (
      .clock     (clock),
      .reset     (reset),
      .in_word   (payload_word),
      .in_last   (payload_last),
      .in_valid  (payload_valid),
      .in_ready  (payload_ready),
      .out_word  (fifo_word),
      .out_last  (fifo_last),
      .out_valid (fifo_valid),
      .out_ready (fifo_ready)
   );

   csi_rx_12bit_unpack csi_rx_12bit_unpack_i (
      .clock      (clock),
      .reset      (reset),
      .data_in    (fifo_word),
      .data_last  (fifo_last),
      .din_valid  (fifo_valid),
      .din_ready  (fifo_ready),
      .data_out   (pixel_data),
      .dout_last  (pixel_last),
      .dout_valid (pixel_valid),
      .dout_ready (pixel_ready)
   );

endmodule

/* source/csi_rx_12bit_unpack.sv */
module csi_rx_12bit_unpack (
   input  logic                       clock,
   input  logic                       reset,
   input  logic [31:0]                data_in,     // payload word from the FIFO
   input  logic                       data_last,   // final word of the packet
   input  logic                       din_valid,
   output logic                       din_ready,
   output csi_rx_pkg::lane_raw_data_t data_out,    // four unpacked pixels
   output logic                       dout_last,
   output logic                       dout_valid,
   input  logic                       dout_ready
);
   import csi_rx_pkg::*;

   logic [1:0]     phase;        // word position within three
   logic [31:0]    byte_hold;    // bytes waiting for the next word
   logic [47:0]    asm_group;    // assembled packed group
   logic           asm_last;
   logic           asm_valid;
   lane_raw_data_t unpacked;
   logic           st2_load;
   logic           st1_free;
   logic           din_fire;
   logic           completes;

   // RAW12 pixel pairs share their low nibbles in a third byte
   function automatic lane_raw_data_t raw12_unpack(input logic [47:0] group);
      logic [5:0][7:0] group_bytes;
      lane_raw_data_t  pixels;
      group_bytes = group;
      for (int k = 0; k < 2; k++) begin
         pixels[2*k]   = {group_bytes[3*k],   group_bytes[3*k+2][3:0]};
         pixels[2*k+1] = {group_bytes[3*k+1], group_bytes[3*k+2][7:4]};
      end
      return pixels;
   endfunction

   assign unpacked = raw12_unpack(asm_group);

   assign st2_load  = !dout_valid || dout_ready;
   assign st1_free  = !asm_valid || st2_load;
   assign din_ready = st1_free;                  // low once both stages are full
   assign din_fire  = din_valid && st1_free;
   assign completes = din_fire && (phase != 2'd0);

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         phase      <= 2'd0;
         asm_valid  <= 1'b0;
         dout_valid <= 1'b0;
      end else begin
         if (din_fire) begin
            if (data_last || (phase == 2'd2)) begin
               phase <= 2'd0;   // realign at each packet end
            end else begin
               phase <= phase + 2'd1;
            end
         end
         if (st1_free) begin
            asm_valid <= completes;
         end
         if (st2_load) begin
            dout_valid <= asm_valid;
         end
      end
   end

   always_ff @(posedge clock) begin
      if (din_fire) begin
         if (phase == 2'd0) begin
            byte_hold <= data_in;
         end else if (phase == 2'd1) begin
            byte_hold <= {16'h0000, data_in[31:16]};   // upper half starts group B
         end
      end
      if (completes) begin
         if (phase == 2'd1) begin
            asm_group <= {data_in[15:0], byte_hold};          // group A
         end else begin
            asm_group <= {data_in, byte_hold[15:0]};          // group B
         end
         asm_last <= data_last;
      end
      if (st2_load && asm_valid) begin
         data_out  <= unpacked;
         dout_last <= asm_last;
      end
   end

   phase_range_a : assert property (@(posedge clock) disable iff (reset)
      phase != 2'd3)
      else $error("word phase reached 3");

endmodule

/* source/csi_packet_handler.sv */
`include "csi_rx_params.svh"

module csi_packet_handler (
   input  logic        clock,
   input  logic        reset,
   input  logic [31:0] lane_data,
   input  logic        lane_valid,
   output logic        lane_ready,
   output logic [31:0] payload_word,
   output logic        payload_last,
   output logic        payload_valid,
   input  logic        payload_ready,
   output logic        packet_error
);
   import csi_rx_pkg::*;

   localparam logic [1:0] ST_HEADER  = 2'd0;
   localparam logic [1:0] ST_PAYLOAD = 2'd1;
   localparam logic [1:0] ST_DISCARD = 2'd2;

   logic [1:0]  state;
   logic [13:0] words_left;      // payload words still to come
   csi_header_u header;
   logic        check_ok;
   logic        type_ok;
   logic        count_ok;
   logic        header_ok;
   logic [13:0] header_words;
   logic        lane_fire;
   logic        last_word;

   assign header = lane_data;

   assign check_ok = (header.bytes[0] ^ header.bytes[1] ^ header.bytes[2]) == header.bytes[3];
   assign type_ok  = header.field.data_type == `CSI_DT_RAW12;

   // whole pixel-group pairs only, 12 bytes each
   assign count_ok = (header.field.word_count != 16'd0) &&
                     (header.field.word_count <= `CSI_MAX_WORD_COUNT) &&
                     ((header.field.word_count % 16'd12) == 16'd0);

   assign header_ok    = check_ok && type_ok && count_ok;
   assign header_words = header.field.word_count[15:2];

   // only the payload state waits on the output register
   assign lane_ready = (state != ST_PAYLOAD) || !payload_valid || payload_ready;
   assign lane_fire  = lane_valid && lane_ready;
   assign last_word  = words_left == 14'd1;

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         state         <= ST_HEADER;
         words_left    <= '0;
         payload_valid <= 1'b0;
         packet_error  <= 1'b0;
      end else begin
         packet_error <= 1'b0;
         if (payload_valid && payload_ready) begin
            payload_valid <= 1'b0;   // drained, may be refilled below
         end
         if (lane_fire) begin
            case (state)
               ST_HEADER: begin
                  words_left <= header_words;
                  if (header_ok) begin
                     state <= ST_PAYLOAD;
                  end else begin
                     packet_error <= 1'b1;
                     if (header_words != 14'd0) begin
                        state <= ST_DISCARD;   // skip the bad payload
                     end
                  end
               end
               ST_PAYLOAD: begin
                  payload_valid <= 1'b1;
                  words_left    <= words_left - 14'd1;
                  if (last_word) begin
                     state <= ST_HEADER;
                  end
               end
               ST_DISCARD: begin
                  words_left <= words_left - 14'd1;
                  if (last_word) begin
                     state <= ST_HEADER;
                  end
               end
               default: begin
                  state <= ST_HEADER;
               end
            endcase
         end
      end
   end

   always_ff @(posedge clock) begin
      if (lane_fire && (state == ST_PAYLOAD)) begin
         payload_word <= lane_data;
         payload_last <= last_word;   // flags the final payload word
      end
   end

   // output register must hold while the FIFO is full
   payload_hold_a : assert property (@(posedge clock) disable iff (reset)
      payload_valid && !payload_ready |=>
         payload_valid && $stable(payload_word) && $stable(payload_last))
      else $error("payload output changed while stalled");

endmodule

/* source/payload_fifo.sv */
`include "csi_rx_params.svh"

module payload_fifo #(
   parameter int depth = `PAYLOAD_FIFO_DEPTH
) (
   input  logic        clock,
   input  logic        reset,
   input  logic [31:0] in_word,
   input  logic        in_last,
   input  logic        in_valid,
   output logic        in_ready,
   output logic [31:0] out_word,
   output logic        out_last,
   output logic        out_valid,
   input  logic        out_ready
);

   localparam int ptr_bits   = (depth > 1) ? $clog2(depth) : 1;
   localparam int count_bits = $clog2(depth + 1);

   logic [31:0]           mem_word [depth];
   logic                  mem_last [depth];
   logic [ptr_bits-1:0]   wr_ptr;
   logic [ptr_bits-1:0]   rd_ptr;
   logic [count_bits-1:0] count;    // words stored
   logic                  wr_en;
   logic                  rd_en;

   // wraps at depth even when not a power of two
   function automatic logic [ptr_bits-1:0] next_ptr(input logic [ptr_bits-1:0] ptr);
      logic [ptr_bits-1:0] result;
      if (ptr == ptr_bits'(depth - 1)) begin
         result = '0;
      end else begin
         result = ptr + 1'b1;
      end
      return result;
   endfunction

   assign in_ready  = count != count_bits'(depth);
   assign out_valid = count != '0;
   assign wr_en     = in_valid && in_ready;
   assign rd_en     = out_valid && out_ready;
   assign out_word  = mem_word[rd_ptr];   // head word read without a register
   assign out_last  = mem_last[rd_ptr];

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (rd_en) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // idle or pass-through
         endcase
      end
   end

   always_ff @(posedge clock) begin
      if (wr_en) begin
         mem_word[wr_ptr] <= in_word;
         mem_last[wr_ptr] <= in_last;
      end
   end

   // a write when full or a read when empty pushes count above depth
   count_range_a : assert property (@(posedge clock) disable iff (reset)
      count <= count_bits'(depth))
      else $error("FIFO written when full or read when empty");

   // full and empty both leave the pointers on the same slot
   ptr_match_a : assert property (@(posedge clock) disable iff (reset)
      (count == '0) || (count == count_bits'(depth)) |-> wr_ptr == rd_ptr)
      else $error("FIFO pointers disagree with the word count");

endmodule

/* source/csi_rx_pkg.sv */
package csi_rx_pkg;

   // one header word, seen as fields or as bytes
   typedef union packed {
      struct packed {
         logic [7:0]  check;         // byte 3, xor of bytes 0..2
         logic [15:0] word_count;    // bytes 1 and 2, low byte first
         logic [1:0]  vc;            // top of data identifier
         logic [5:0]  data_type;     // bottom of data identifier
      } field;
      logic [3:0][7:0] bytes;        // bytes[0] is the data identifier
   } csi_header_u;

   // four unpacked pixels, pixel 0 in the low bits
   typedef logic [3:0][11:0] lane_raw_data_t;

endpackage

/* source/csi_rx_params.svh */
`ifndef CSI_RX_PARAMS_SVH
`define CSI_RX_PARAMS_SVH

// RAW12 data identifier, low 6 bits of header byte 0
`define CSI_DT_RAW12 6'h2C

// payload words buffered between handler and unpacker
`define PAYLOAD_FIFO_DEPTH 8

// bytes, largest long packet accepted
`define CSI_MAX_WORD_COUNT 16'd4092

`endif
